// File: sim.f
source/fastCyclePkg.sv
source/fastVram.sv
source/vramArbiter.sv
source/spriteParser.sv
source/activeListReader.sv
source/fastCycle.sv
sim/fastCycleTb.sv

// File: sim/fastCycleTb.sv
// Fast sprite-VRAM cycle testbench, directed tests checked against a model of the match rule
module fastCycleTb
	import fastCyclePkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int parseCount    = 381;
	localparam int maxActive     = 96;
	localparam int lineTests     = 4;
	localparam int timeoutCycles = 10 * (parseCount * 4 + 200) * lineTests;

	logic        clk24M;
	logic        reset;
	logic        cpuStrobe;
	vramReqT     cpuReq;
	logic        newLine;
	rasterLineT  rasterLine;
	logic        readStart;
	logic        cpuDone;
	vramWordT    cpuReadData;
	logic        parseDone;
	logic        activeValid;
	spriteIndexT activeIndex;
	logic        listEnd;

	// Mirror of every CPU write
	vramWordT    model [0:2047];
	spriteIndexT expected [$];
	int          delivered;
	int          valueErrors;
	int          otherErrors;
	int          cycles;

	fastCycle dut (
		.clk24M      (clk24M),
		.reset       (reset),
		.cpuStrobe   (cpuStrobe),
		.cpuReq      (cpuReq),
		.newLine     (newLine),
		.rasterLine  (rasterLine),
		.readStart   (readStart),
		.cpuDone     (cpuDone),
		.cpuReadData (cpuReadData),
		.parseDone   (parseDone),
		.activeValid (activeValid),
		.activeIndex (activeIndex),
		.listEnd     (listEnd)
	);

	initial begin
		clk24M = 1'b0;
		forever #10 clk24M = ~clk24M;
	end

	initial begin
		cycles = 0;
		while (cycles < timeoutCycles) begin
			@(posedge clk24M);
			cycles++;
		end
		$display("Timeout after %0d cycles, the tests did not finish", cycles);
		$display("*** FAILED ***");
		$finish;
	end

	task automatic checkWord(input string testName, input vramWordT exp, input vramWordT act);
		if (exp !== act) begin
			$display("[FAIL] %s expected %h actual %h", testName, exp, act);
			valueErrors++;
		end
	endtask

	task automatic checkIndex(input string testName, input spriteIndexT exp,
			input spriteIndexT act);
		if (exp !== act) begin
			$display("[FAIL] %s expected %0d actual %0d", testName, exp, act);
			valueErrors++;
		end
	endtask

	task automatic checkCount(input string testName, input listCountT exp, input listCountT act);
		if (exp !== act) begin
			$display("[FAIL] %s expected %0d actual %0d", testName, exp, act);
			valueErrors++;
		end
	endtask

	// Strobe one CPU access and wait for cpuDone
	task automatic cpuAccess(input vramAddrT addr, input vramWordT data, input logic write,
			output vramWordT result);
		vramReqT req;
		int      waited;
		req.addr  = addr;
		req.data  = data;
		req.write = write;
		@(posedge clk24M);
		cpuStrobe <= 1'b1;
		cpuReq    <= req;
		@(posedge clk24M);
		cpuStrobe <= 1'b0;
		waited = 1;
		@(negedge clk24M);
		while (!cpuDone && waited < 5) begin
			@(negedge clk24M);
			waited++;
		end
		if (!cpuDone) begin
			$display("CPU access to %h got no cpuDone within 5 cycles of its strobe", addr);
			otherErrors++;
		end
		result = cpuReadData;
	endtask

	task automatic cpuWrite(input vramAddrT addr, input vramWordT data, input string testName);
		vramWordT result;
		cpuAccess(addr, data, 1'b1, result);
		checkWord(testName, data, result);
		model[addr] = data;
	endtask

	task automatic cpuReadCheck(input vramAddrT addr, input vramWordT exp,
			input string testName);
		vramWordT result;
		cpuAccess(addr, '0, 1'b0, result);
		checkWord(testName, exp, result);
	endtask

	task automatic writeYWord(input int sprite, input int yPos, input logic chain,
			input int size);
		yAttrT attr;
		attr.yPos  = 9'(yPos);
		attr.chain = chain;
		attr.size  = 6'(size);
		cpuWrite(yTableBase + vramAddrT'(sprite), vramWordT'(attr), "Y table write echo");
	endtask

	// Expected active list for a line from the mirrored Y table
	function automatic void buildExpected(input int line);
		int    s;
		int    top;
		int    delta;
		int    height;
		logic  prev;
		logic  active;
		yAttrT attr;
		expected.delete();
		prev = 1'b0;
		for (s = 0; s < parseCount && expected.size() < maxActive; s++) begin
			attr   = yAttrT'(model[yTableBase + s]);
			top    = (496 - int'(attr.yPos)) & 511;
			delta  = (line - top) & 511;
			height = int'(attr.size) * 16;
			if (attr.chain) begin
				active = prev;
			end else begin
				active = attr.size[5] || (delta < height);
			end
			if (active) begin
				expected.push_back(spriteIndexT'(s));
			end
			prev = active;
		end
	endfunction

	// Parse a line, hand it over with the next line and play it back
	task automatic runLine(input rasterLineT line, input string testName);
		int   waited;
		int   k;
		logic seenEnd;
		buildExpected(int'(line));
		@(posedge clk24M);
		newLine    <= 1'b1;
		rasterLine <= line;
		@(posedge clk24M);
		newLine <= 1'b0;
		waited = 0;
		@(negedge clk24M);
		while (!parseDone && waited < parseCount * 4 + 200) begin
			@(negedge clk24M);
			waited++;
		end
		if (!parseDone) begin
			$display("%s: parseDone never rose for line %0d", testName, line);
			otherErrors++;
		end
		@(posedge clk24M);
		newLine    <= 1'b1;
		rasterLine <= line + 9'd1;
		@(posedge clk24M);
		newLine   <= 1'b0;
		readStart <= 1'b1;
		@(posedge clk24M);
		readStart <= 1'b0;
		k       = 0;
		waited  = 0;
		seenEnd = 1'b0;
		while (!seenEnd && waited < maxActive * 4 + 50) begin
			@(negedge clk24M);
			waited++;
			if (activeValid) begin
				if (k < expected.size()) begin
					checkIndex(testName, expected[k], activeIndex);
				end else begin
					$display("%s: the DUT delivered more entries than expected", testName);
					otherErrors++;
				end
				k++;
			end
			if (listEnd) begin
				seenEnd = 1'b1;
			end
		end
		if (!seenEnd) begin
			$display("%s: listEnd never arrived after the playback", testName);
			otherErrors++;
		end
		delivered = k;
		checkCount(testName, listCountT'(expected.size()), listCountT'(k));
	endtask

	task automatic loadRandomTable();
		int s;
		for (s = 0; s < parseCount; s++) begin
			writeYWord(s, $urandom_range(0, 511), 1'b0, $urandom_range(0, 7));
		end
	endtask

	task automatic resetTest();
		@(negedge clk24M);
		if (cpuDone || activeValid || listEnd || parseDone) begin
			$display("Reset outputs high: cpuDone %b activeValid %b listEnd %b parseDone %b",
				cpuDone, activeValid, listEnd, parseDone);
			otherErrors++;
		end
	endtask

	task automatic cpuTest();
		vramAddrT addrs [16];
		int       i;
		for (i = 0; i < 16; i++) begin
			addrs[i] = vramAddrT'($urandom_range(0, 11'h1ff));
			cpuWrite(addrs[i], vramWordT'($urandom), "cpu write echo");
		end
		for (i = 0; i < 16; i++) begin
			cpuReadCheck(addrs[i], model[addrs[i]], "cpu read back");
		end
	endtask

	task automatic lineParseTest();
		rasterLineT line;
		int         k;
		int         s;
		loadRandomTable();
		line = rasterLineT'($urandom_range(0, 510));
		runLine(line, "line parse A");
		// List half of line A stays intact while the next line fills the other half
		for (k = 0; k < expected.size(); k++) begin
			cpuReadCheck(listBase + (line[0] ? listStride : 11'h000) + vramAddrT'(k),
				vramWordT'(expected[k]), "list contents");
		end
		for (s = 0; s < parseCount; s++) begin
			cpuReadCheck(yTableBase + vramAddrT'(s), model[yTableBase + s], "Y table unchanged");
		end
		line = rasterLineT'($urandom_range(0, 510));
		runLine(line, "line parse B");
	endtask

	task automatic chainTest();
		int s;
		// Chained sprite 0 has no active leader
		writeYWord(0, 0, 1'b1, 6'h20);
		writeYWord(40, 0, 1'b0, 6'h20);
		for (s = 41; s < 44; s++) begin
			writeYWord(s, 0, 1'b1, 6'h00);
		end
		writeYWord(44, 0, 1'b0, 6'h00);
		for (s = 45; s < 48; s++) begin
			writeYWord(s, 0, 1'b1, 6'h20);
		end
		runLine(rasterLineT'($urandom_range(0, 510)), "chains");
	endtask

	task automatic fullListTest();
		int s;
		for (s = 0; s < parseCount; s++) begin
			writeYWord(s, $urandom_range(0, 511), 1'b0, 6'h20);
		end
		runLine(rasterLineT'($urandom_range(0, 510)), "full list");
		checkCount("full list length", listCountT'(maxActive), listCountT'(delivered));
	endtask

	initial begin
		void'($urandom(32'hb25750d9));
		reset       = 1'b1;
		cpuStrobe   = 1'b0;
		cpuReq      = '0;
		newLine     = 1'b0;
		rasterLine  = '0;
		readStart   = 1'b0;
		delivered   = 0;
		valueErrors = 0;
		otherErrors = 0;
		repeat (2) @(posedge clk24M);
		reset <= 1'b0;
		resetTest();
		cpuTest();
		lineParseTest();
		chainTest();
		fullListTest();
		$display("Run complete: %0d value errors, %0d other errors", valueErrors, otherErrors);
		if (valueErrors + otherErrors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// File: source/activeListReader.sv
// Active list reader, plays back the list built during the previous line
module activeListReader
	import fastCyclePkg::*;
#(
	parameter int maxActive = 96
) (
	input  logic        clk24M,
	input  logic        reset,
	input  slotT        slot,
	input  logic        readStart,
	input  listCountT   lastCount,
	input  logic        lastParity,
	input  vramWordT    readData,
	output vramReqT     listReq,
	output logic        activeValid,
	output spriteIndexT activeIndex,
	output logic        listEnd
);

	listCountT readPtr;
	listCountT total;
	logic      half;
	logic      running;
	logic      issue;

	assign issue = running && (slot == slotListRead) && (readPtr < total);

	assign listReq.addr  = listBase + (half ? listStride : '0) + vramAddrT'(readPtr);
	assign listReq.data  = '0;
	assign listReq.write = 1'b0;

	// Entry arrives the cycle after its read
	assign activeIndex = readData[8:0];

	always_ff @(posedge clk24M) begin
		if (reset) begin
			readPtr     <= '0;
			total       <= '0;
			half        <= 1'b0;
			running     <= 1'b0;
			activeValid <= 1'b0;
			listEnd     <= 1'b0;
		end else if (readStart) begin
			readPtr     <= '0;
			total       <= (lastCount > maxActive) ? listCountT'(maxActive) : lastCount;
			half        <= lastParity;
			running     <= lastCount != '0;
			activeValid <= 1'b0;
			// Empty list ends at once
			listEnd     <= lastCount == '0;
		end else begin
			activeValid <= issue;
			listEnd     <= 1'b0;
			if (issue) begin
				readPtr <= readPtr + 7'd1;
			end
			if (running && activeValid && readPtr == total) begin
				running <= 1'b0;
				listEnd <= 1'b1;
			end
		end
	end

endmodule

// File: source/fastCycle.sv
// Fast sprite-VRAM cycle top level, arbiter, RAM, Y parser and list reader
module fastCycle
	import fastCyclePkg::*;
#(
	parameter int parseCount = 381,
	parameter int maxActive  = 96
) (
	input  logic        clk24M,
	input  logic        reset,
	input  logic        cpuStrobe,
	input  vramReqT     cpuReq,
	input  logic        newLine,
	input  rasterLineT  rasterLine,
	input  logic        readStart,
	output logic        cpuDone,
	output vramWordT    cpuReadData,
	output logic        parseDone,
	output logic        activeValid,
	output spriteIndexT activeIndex,
	output logic        listEnd
);

	vramReqT   ramReq;
	vramReqT   parseReq;
	vramReqT   listReq;
	vramWordT  ramData;
	slotT      slot;
	listCountT lastCount;
	logic      lastParity;

	vramArbiter arbiter (
		.clk24M      (clk24M),
		.reset       (reset),
		.cpuStrobe   (cpuStrobe),
		.cpuReq      (cpuReq),
		.parseReq    (parseReq),
		.listReq     (listReq),
		.ramData     (ramData),
		.ramReq      (ramReq),
		.slot        (slot),
		.cpuDone     (cpuDone),
		.cpuReadData (cpuReadData)
	);

	fastVram vram (
		.clk24M   (clk24M),
		.req      (ramReq),
		.readData (ramData)
	);

	spriteParser #(
		.parseCount (parseCount),
		.maxActive  (maxActive)
	) parser (
		.clk24M     (clk24M),
		.reset      (reset),
		.slot       (slot),
		.newLine    (newLine),
		.rasterLine (rasterLine),
		.readData   (ramData),
		.parseReq   (parseReq),
		.parseDone  (parseDone),
		.lastCount  (lastCount),
		.lastParity (lastParity)
	);

	// Playback of the previous line's list
	activeListReader #(
		.maxActive (maxActive)
	) reader (
		.clk24M      (clk24M),
		.reset       (reset),
		.slot        (slot),
		.readStart   (readStart),
		.lastCount   (lastCount),
		.lastParity  (lastParity),
		.readData    (ramData),
		.listReq     (listReq),
		.activeValid (activeValid),
		.activeIndex (activeIndex),
		.listEnd     (listEnd)
	);

endmodule

// File: source/fastCyclePkg.sv
// Fast VRAM cycle shared types, region bases and request structs
package fastCyclePkg;

	// Basic widths
	typedef logic [10:0] vramAddrT;
	typedef logic [15:0] vramWordT;
	typedef logic [8:0]  spriteIndexT;
	typedef logic [8:0]  rasterLineT;
	typedef logic [6:0]  listCountT;

	// Four-slot rotation, stepped once per clock
	typedef enum logic [1:0] {
		slotCpu        = 2'd0,
		slotParseRead  = 2'd1,
		slotParseWrite = 2'd2,
		slotListRead   = 2'd3
	} slotT;

	// Y-attribute word layout
	typedef struct packed {
		logic [8:0] yPos;
		logic       chain;
		logic [5:0] size;
	} yAttrT;

	// One RAM access, read when write is clear
	typedef struct packed {
		vramAddrT addr;
		vramWordT data;
		logic     write;
	} vramReqT;

	// Y table, one word per sprite
	localparam vramAddrT yTableBase = 11'h200;

	// Active lists, one half per line parity
	localparam vramAddrT listBase   = 11'h600;
	localparam vramAddrT listStride = 11'h080;

	// Top line is (yOffset - yPos) mod 512
	localparam rasterLineT yOffset = 9'd496;

endpackage

// File: source/fastVram.sv
// Fast VRAM, 2048 x 16 single-port synchronous RAM with one-cycle read latency
module fastVram
	import fastCyclePkg::*;
(
	input  logic     clk24M,
	input  vramReqT  req,
	output vramWordT readData
);

	vramWordT mem [0:2047];

	// Write through the port, or register the addressed word
	always_ff @(posedge clk24M) begin
		if (req.write) begin
			mem[req.addr] <= req.data;
		end else begin
			readData <= mem[req.addr];
		end
	end

endmodule

// File: source/spriteParser.sv
// Sprite parser, walks the Y table each line and builds the active list
module spriteParser
	import fastCyclePkg::*;
#(
	parameter int parseCount = 381,
	parameter int maxActive  = 96
) (
	input  logic       clk24M,
	input  logic       reset,
	input  slotT       slot,
	input  logic       newLine,
	input  rasterLineT rasterLine,
	input  vramWordT   readData,
	output vramReqT    parseReq,
	output logic       parseDone,
	output listCountT  lastCount,
	output logic       lastParity
);

	spriteIndexT index;
	listCountT   count;
	rasterLineT  line;
	logic        prevActive;
	logic        stepValid;

	yAttrT       attr;
	rasterLineT  topLine;
	rasterLineT  lineDelta;
	logic        inRange;
	logic        isActive;
	spriteIndexT nextIndex;
	listCountT   nextCount;
	vramAddrT    listHalf;

	// Match against the word fetched in the read slot
	assign attr      = yAttrT'(readData);
	assign topLine   = yOffset - attr.yPos;
	assign lineDelta = line - topLine;
	assign inRange   = {1'b0, lineDelta} < {attr.size, 4'b0000};

	// Chained sprites follow the one before them
	assign isActive = attr.chain ? prevActive : (attr.size[5] || inRange);

	assign nextIndex = index + 9'd1;
	assign nextCount = isActive ? count + 7'd1 : count;
	assign listHalf  = line[0] ? listStride : '0;

	always_comb begin
		parseReq = '0;
		if (slot == slotParseRead) begin
			parseReq.addr = yTableBase + vramAddrT'(index);
		end else if (slot == slotParseWrite) begin
			parseReq.addr  = listBase + listHalf + vramAddrT'(count);
			parseReq.data  = vramWordT'(index);
			parseReq.write = stepValid && isActive;
		end
	end

	always_ff @(posedge clk24M) begin
		if (reset) begin
			index      <= '0;
			count      <= '0;
			line       <= '0;
			prevActive <= 1'b0;
			stepValid  <= 1'b0;
			parseDone  <= 1'b0;
			lastCount  <= '0;
			lastParity <= 1'b0;
		end else if (newLine) begin
			// Hand the finished list over and restart
			lastCount  <= count;
			lastParity <= line[0];
			line       <= rasterLine;
			index      <= '0;
			count      <= '0;
			prevActive <= 1'b0;
			stepValid  <= 1'b0;
			parseDone  <= 1'b0;
		end else begin
			stepValid <= (slot == slotParseRead) && !parseDone;
			if (stepValid) begin
				index      <= nextIndex;
				count      <= nextCount;
				prevActive <= isActive;
				// End of table or list full
				if (nextIndex == parseCount || nextCount == maxActive) begin
					parseDone <= 1'b1;
				end
			end
		end
	end

endmodule

// File: source/vramArbiter.sv
// VRAM arbiter, four-slot rotation with CPU request latch and read-data return
module vramArbiter
	import fastCyclePkg::*;
(
	input  logic     clk24M,
	input  logic     reset,
	input  logic     cpuStrobe,
	input  vramReqT  cpuReq,
	input  vramReqT  parseReq,
	input  vramReqT  listReq,
	input  vramWordT ramData,
	output vramReqT  ramReq,
	output slotT     slot,
	output logic     cpuDone,
	output vramWordT cpuReadData
);

	logic     cpuPending;
	vramReqT  pendingReq;
	logic     cpuIssue;
	logic     issuedWrite;
	vramWordT issuedData;

	assign cpuIssue = (slot == slotCpu) && cpuPending;

	// Slot counter
	always_ff @(posedge clk24M) begin
		if (reset) begin
			slot <= slotCpu;
		end else begin
			slot <= slotT'(slot + 2'd1);
		end
	end

	// Pending CPU access, extra strobes dropped while one waits
	always_ff @(posedge clk24M) begin
		if (reset) begin
			cpuPending <= 1'b0;
			cpuDone    <= 1'b0;
		end else begin
			cpuDone <= cpuIssue;
			if (cpuIssue) begin
				cpuPending <= 1'b0;
			end else if (cpuStrobe && !cpuPending) begin
				cpuPending <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk24M) begin
		if (cpuStrobe && !cpuPending) begin
			pendingReq <= cpuReq;
		end
		if (cpuIssue) begin
			issuedWrite <= pendingReq.write;
			issuedData  <= pendingReq.data;
		end
	end

	// Writes echo their own data back to the CPU
	assign cpuReadData = issuedWrite ? issuedData : ramData;

	// Owner of the current slot drives the RAM
	always_comb begin
		case (slot)
			slotCpu:        ramReq = cpuPending ? pendingReq : '0;
			slotParseRead:  ramReq = parseReq;
			slotParseWrite: ramReq = parseReq;
			slotListRead:   ramReq = listReq;
			default:        ramReq = '0;
		endcase
	end

endmodule
